/* hdl/memBusPkg.sv */
package memBusPkg;

  // one data word on the memory bus
  localparam int wordBits = 32;

  // words per memory block, also words per cache line
  localparam int blockWords = 4;

  // one whole block as returned by the memory
  localparam int blockBits = wordBits * blockWords;

  // opcode from arbiter to memory
  // MEM_IDLE means no access in flight
  typedef enum logic [1:0]
  {
    MEM_IDLE,
    MEM_READ,
    MEM_WRITE
  } memOp;

endpackage

/* hdl/cacheTypesPkg.sv */
package cacheTypesPkg;

  // cache controller states, shared by both caches
  // C_IDLE is the cycle after reset or after a completion
  typedef enum logic [1:0]
  {
    C_IDLE,
    C_LOOKUP,
    C_FILL,
    C_WRITE
  } cacheState;

  // arbiter state, the side that currently owns the memory
  typedef enum logic [1:0]
  {
    G_NONE,
    G_INSTR,
    G_DATA
  } arbGrant;

endpackage

/* hdl/blockMemory.sv */
`timescale 1ns/10ps

module blockMemory #(
  parameter int waitCycles = 3,
  parameter int memAddrBits = 12
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  memBusPkg::memOp                 op,
  input  logic [memAddrBits-1:0]          addr,
  input  logic [memBusPkg::wordBits-1:0]  wd,
  output logic [memBusPkg::blockBits-1:0] rd,
  output logic                            valid
);

  localparam int words = 2 ** memAddrBits;
  localparam int offBits = $clog2(memBusPkg::blockWords);
  // wide enough to hold waitCycles, one bit minimum
  localparam int countBits = (waitCycles > 0) ? $clog2(waitCycles + 1) : 1;

  typedef enum logic [1:0]
  {
    IDLE,
    REQUESTED,
    RETRIEVED
  } memState;

  memState state;
  logic [countBits-1:0] count;
  logic [memBusPkg::wordBits-1:0] mem [words];
  logic [memAddrBits-offBits-1:0] blockAddr;

  // storage starts out all zero
  initial
  begin
    for (int i = 0; i < words; i++)
    begin
      mem[i] = '0;
    end
  end

  // access timing
  // request sampled only while idle, then waitCycles+1 edges of wait
  // so the pulse is seen waitCycles+2 edges after the sampling edge
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= IDLE;
      count <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          count <= '0;
          if (op != memBusPkg::MEM_IDLE)
            state <= REQUESTED;
        end
        REQUESTED:
        begin
          if (count == countBits'(waitCycles))
            state <= RETRIEVED;
          else
            count <= count + 1'b1;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // exactly one cycle per access
  assign valid = (state == RETRIEVED);

  // write lands on the sampling edge
  always_ff @(posedge clk)
  begin
    if (state == IDLE && op == memBusPkg::MEM_WRITE)
      mem[addr] <= wd;
  end

  // aligned block around addr, word 0 in the top slot
  assign blockAddr = addr[memAddrBits-1:offBits];

  always_comb
  begin
    for (int k = 0; k < memBusPkg::blockWords; k++)
    begin
      rd[(memBusPkg::blockWords - 1 - k) * memBusPkg::wordBits +: memBusPkg::wordBits] =
        mem[{blockAddr, offBits'(k)}];
    end
  end

endmodule

/* hdl/instrCache.sv */
`timescale 1ns/10ps

module instrCache #(
  parameter int memAddrBits = 12,
  parameter int indexBits = 3,
  localparam int offBits = $clog2(memBusPkg::blockWords)
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            iRe,
  input  logic [memAddrBits+1:0]          iAddr,
  output logic [memBusPkg::wordBits-1:0]  iRd,
  output logic                            iValid,
  output logic                            fillReq,
  output logic [memAddrBits-offBits-1:0]  fillAddr,
  input  logic                            fillDone,
  input  logic [memBusPkg::blockBits-1:0] fillBlock
);

  localparam int lines = 2 ** indexBits;
  localparam int tagBits = memAddrBits - offBits - indexBits;

  cacheTypesPkg::cacheState state;

  logic [lines-1:0] lineValid;
  logic [tagBits-1:0] lineTag [lines];
  logic [memBusPkg::blockBits-1:0] lineData [lines];

  logic [offBits-1:0] slot;
  logic [indexBits-1:0] index;
  logic [tagBits-1:0] tag;
  logic hit;
  logic fillWrite;

  // byte address split into tag, index and word offset
  assign index = iAddr[offBits+2 +: indexBits];
  assign tag = iAddr[memAddrBits+1 -: tagBits];
  // word 0 sits in the top slot of a block
  assign slot = ~iAddr[offBits+1:2];

  assign hit = lineValid[index] && (lineTag[index] == tag);

  // miss raises the fill at once and holds it through C_FILL
  assign fillReq = (state == cacheTypesPkg::C_FILL) ||
                   (state == cacheTypesPkg::C_LOOKUP && iRe && !hit);
  assign fillAddr = iAddr[memAddrBits+1:offBits+2];

  assign fillWrite = (state == cacheTypesPkg::C_FILL) && fillDone;

  // controller
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= cacheTypesPkg::C_IDLE;
      iValid <= 1'b0;
    end
    else
    begin
      iValid <= 1'b0;
      case (state)
        cacheTypesPkg::C_LOOKUP:
        begin
          if (iRe && hit)
          begin
            iValid <= 1'b1;
            state <= cacheTypesPkg::C_IDLE;
          end
          else if (iRe)
            state <= cacheTypesPkg::C_FILL;
        end
        cacheTypesPkg::C_FILL:
        begin
          if (fillDone)
          begin
            iValid <= 1'b1;
            state <= cacheTypesPkg::C_IDLE;
          end
        end
        // idle cycle covers the valid pulse, held request ignored
        default:
          state <= cacheTypesPkg::C_LOOKUP;
      endcase
    end
  end

  // returned word, from the line on a hit or straight from the fill
  always_ff @(posedge clk)
  begin
    if (state == cacheTypesPkg::C_LOOKUP && iRe && hit)
      iRd <= lineData[index][slot * memBusPkg::wordBits +: memBusPkg::wordBits];
    else if (fillWrite)
      iRd <= fillBlock[slot * memBusPkg::wordBits +: memBusPkg::wordBits];
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      lineValid <= '0;
    else if (fillWrite)
      lineValid[index] <= 1'b1;
  end

  // line refill
  always_ff @(posedge clk)
  begin
    if (fillWrite)
    begin
      lineTag[index] <= tag;
      lineData[index] <= fillBlock;
    end
  end

endmodule

/* hdl/dataCache.sv */
`timescale 1ns/10ps

module dataCache #(
  parameter int memAddrBits = 12,
  parameter int indexBits = 3
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            dRe,
  input  logic                            dWe,
  input  logic [memAddrBits+1:0]          dAddr,
  input  logic [memBusPkg::wordBits-1:0]  dWd,
  output logic [memBusPkg::wordBits-1:0]  dRd,
  output logic                            dValid,
  output logic                            fillReq,
  output logic                            writeReq,
  output logic [memAddrBits-1:0]          memAddr,
  output logic [memBusPkg::wordBits-1:0]  memWd,
  input  logic                            memDone,
  input  logic [memBusPkg::blockBits-1:0] memBlock
);

  localparam int offBits = $clog2(memBusPkg::blockWords);
  localparam int lines = 2 ** indexBits;
  localparam int tagBits = memAddrBits - offBits - indexBits;

  cacheTypesPkg::cacheState state;

  logic [lines-1:0] lineValid;
  logic [tagBits-1:0] lineTag [lines];
  logic [memBusPkg::blockBits-1:0] lineData [lines];

  logic [offBits-1:0] slot;
  logic [indexBits-1:0] index;
  logic [tagBits-1:0] tag;
  logic hit;
  logic lookup;
  logic fillWrite;
  logic wordWrite;

  assign index = dAddr[offBits+2 +: indexBits];
  assign tag = dAddr[memAddrBits+1 -: tagBits];
  // word 0 sits in the top slot of a block
  assign slot = ~dAddr[offBits+1:2];

  assign hit = lineValid[index] && (lineTag[index] == tag);
  assign lookup = (state == cacheTypesPkg::C_LOOKUP);

  // store wins over load when both are raised
  assign writeReq = (state == cacheTypesPkg::C_WRITE) || (lookup && dWe);
  assign fillReq = (state == cacheTypesPkg::C_FILL) || (lookup && dRe && !dWe && !hit);

  // word address for both fills and stores
  assign memAddr = dAddr[memAddrBits+1:2];
  assign memWd = dWd;

  assign fillWrite = (state == cacheTypesPkg::C_FILL) && memDone;
  // write-through, cached copy patched only if the line is present
  assign wordWrite = (state == cacheTypesPkg::C_WRITE) && memDone && hit;

  // controller
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= cacheTypesPkg::C_IDLE;
      dValid <= 1'b0;
    end
    else
    begin
      dValid <= 1'b0;
      case (state)
        cacheTypesPkg::C_LOOKUP:
        begin
          if (dWe)
            state <= cacheTypesPkg::C_WRITE;
          else if (dRe && hit)
          begin
            dValid <= 1'b1;
            state <= cacheTypesPkg::C_IDLE;
          end
          else if (dRe)
            state <= cacheTypesPkg::C_FILL;
        end
        // fill and store both end on the arbiter's done pulse
        cacheTypesPkg::C_FILL,
        cacheTypesPkg::C_WRITE:
        begin
          if (memDone)
          begin
            dValid <= 1'b1;
            state <= cacheTypesPkg::C_IDLE;
          end
        end
        default:
          state <= cacheTypesPkg::C_LOOKUP;
      endcase
    end
  end

  // load data, from the line on a hit or from the fill block
  always_ff @(posedge clk)
  begin
    if (lookup && dRe && !dWe && hit)
      dRd <= lineData[index][slot * memBusPkg::wordBits +: memBusPkg::wordBits];
    else if (fillWrite)
      dRd <= memBlock[slot * memBusPkg::wordBits +: memBusPkg::wordBits];
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      lineValid <= '0;
    else if (fillWrite)
      lineValid[index] <= 1'b1;
  end

  // whole line on a fill, single word on a store hit
  always_ff @(posedge clk)
  begin
    if (fillWrite)
    begin
      lineTag[index] <= tag;
      lineData[index] <= memBlock;
    end
    else if (wordWrite)
      lineData[index][slot * memBusPkg::wordBits +: memBusPkg::wordBits] <= dWd;
  end

endmodule

/* hdl/memArbiter.sv */
`timescale 1ns/10ps

module memArbiter #(
  parameter int memAddrBits = 12,
  localparam int offBits = $clog2(memBusPkg::blockWords)
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           iFillReq,
  input  logic [memAddrBits-offBits-1:0] iFillAddr,
  output logic                           iDone,
  input  logic                           dFillReq,
  input  logic                           dWriteReq,
  input  logic [memAddrBits-1:0]         dAddr,
  input  logic [memBusPkg::wordBits-1:0] dWd,
  output logic                           dDone,
  output memBusPkg::memOp                op,
  output logic [memAddrBits-1:0]         addr,
  output logic [memBusPkg::wordBits-1:0] wd,
  input  logic                           valid
);

  cacheTypesPkg::arbGrant grant;

  // set when the data side was the last one served
  logic lastData;
  logic dReq;
  logic pickData;

  assign dReq = dFillReq || dWriteReq;
  // on a tie the side not served last goes first
  assign pickData = dReq && (!iFillReq || !lastData);

  // grant held until the memory pulses valid
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      grant <= cacheTypesPkg::G_NONE;
      op <= memBusPkg::MEM_IDLE;
      lastData <= 1'b0;
    end
    else if (grant == cacheTypesPkg::G_NONE)
    begin
      if (pickData)
      begin
        grant <= cacheTypesPkg::G_DATA;
        op <= dWriteReq ? memBusPkg::MEM_WRITE : memBusPkg::MEM_READ;
        lastData <= 1'b1;
      end
      else if (iFillReq)
      begin
        grant <= cacheTypesPkg::G_INSTR;
        op <= memBusPkg::MEM_READ;
        lastData <= 1'b0;
      end
    end
    else if (valid)
    begin
      grant <= cacheTypesPkg::G_NONE;
      op <= memBusPkg::MEM_IDLE;
    end
  end

  // address and write word latched together with the grant
  always_ff @(posedge clk)
  begin
    if (grant == cacheTypesPkg::G_NONE)
    begin
      addr <= pickData ? dAddr : {iFillAddr, offBits'(0)};
      wd <= dWd;
    end
  end

  // completion goes back only to the owner
  assign iDone = valid && (grant == cacheTypesPkg::G_INSTR);
  assign dDone = valid && (grant == cacheTypesPkg::G_DATA);

endmodule

/* hdl/memSubsystem.sv */
`timescale 1ns/10ps

module memSubsystem #(
  parameter int waitCycles = 3,
  parameter int memAddrBits = 12,
  parameter int indexBits = 3,
  localparam int offBits = $clog2(memBusPkg::blockWords)
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           iRe,
  input  logic [memAddrBits+1:0]         iAddr,
  output logic [memBusPkg::wordBits-1:0] iRd,
  output logic                           iValid,
  input  logic                           dRe,
  input  logic                           dWe,
  input  logic [memAddrBits+1:0]         dAddr,
  input  logic [memBusPkg::wordBits-1:0] dWd,
  output logic [memBusPkg::wordBits-1:0] dRd,
  output logic                           dValid
);

  // instruction cache to arbiter
  logic iFillReq;
  logic [memAddrBits-offBits-1:0] iFillAddr;
  logic iFillDone;

  // data cache to arbiter
  logic dFillReq;
  logic dWriteReq;
  logic [memAddrBits-1:0] dMemAddr;
  logic [memBusPkg::wordBits-1:0] dMemWd;
  logic dMemDone;

  // arbiter to memory, block data fans out to both caches
  memBusPkg::memOp memOp;
  logic [memAddrBits-1:0] memAddr;
  logic [memBusPkg::wordBits-1:0] memWd;
  logic [memBusPkg::blockBits-1:0] memRd;
  logic memValid;

  instrCache #(
    .memAddrBits(memAddrBits),
    .indexBits(indexBits)
  ) iCache (
    .clk(clk),
    .rstN(rstN),
    .iRe(iRe),
    .iAddr(iAddr),
    .iRd(iRd),
    .iValid(iValid),
    .fillReq(iFillReq),
    .fillAddr(iFillAddr),
    .fillDone(iFillDone),
    .fillBlock(memRd)
  );

  dataCache #(
    .memAddrBits(memAddrBits),
    .indexBits(indexBits)
  ) dCache (
    .clk(clk),
    .rstN(rstN),
    .dRe(dRe),
    .dWe(dWe),
    .dAddr(dAddr),
    .dWd(dWd),
    .dRd(dRd),
    .dValid(dValid),
    .fillReq(dFillReq),
    .writeReq(dWriteReq),
    .memAddr(dMemAddr),
    .memWd(dMemWd),
    .memDone(dMemDone),
    .memBlock(memRd)
  );

  memArbiter #(
    .memAddrBits(memAddrBits)
  ) arbiter (
    .clk(clk),
    .rstN(rstN),
    .iFillReq(iFillReq),
    .iFillAddr(iFillAddr),
    .iDone(iFillDone),
    .dFillReq(dFillReq),
    .dWriteReq(dWriteReq),
    .dAddr(dMemAddr),
    .dWd(dMemWd),
    .dDone(dMemDone),
    .op(memOp),
    .addr(memAddr),
    .wd(memWd),
    .valid(memValid)
  );

  blockMemory #(
    .waitCycles(waitCycles),
    .memAddrBits(memAddrBits)
  ) memory (
    .clk(clk),
    .rstN(rstN),
    .op(memOp),
    .addr(memAddr),
    .wd(memWd),
    .rd(memRd),
    .valid(memValid)
  );

endmodule

/* tb/memChecker.sv */
`timescale 1ns/10ps

module memChecker #(
  parameter int waitCycles = 3,
  parameter int memAddrBits = 12,
  parameter int indexBits = 3
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           iRe,
  input  logic [memAddrBits+1:0]         iAddr,
  input  logic [memBusPkg::wordBits-1:0] iRd,
  input  logic                           iValid,
  input  logic                           dRe,
  input  logic                           dWe,
  input  logic [memAddrBits+1:0]         dAddr,
  input  logic [memBusPkg::wordBits-1:0] dWd,
  input  logic [memBusPkg::wordBits-1:0] dRd,
  input  logic                           dValid,
  output int                             valueErrors,
  output int                             latencyErrors,
  output int                             protocolErrors,
  output int                             completions
);

  localparam int lines = 2 ** indexBits;
  // one memory turn, then the worst case of waiting behind the other cache
  localparam int missMin = waitCycles + 4;
  localparam int missMax = 2 * (waitCycles + 4);

  // reference memory, all zero at start like the DUT storage
  logic [memBusPkg::wordBits-1:0] model [2 ** memAddrBits];
  // block number held in each cache line, -1 when empty
  int iLine [lines];
  int dLine [lines];

  int cycle;
  // fetch in flight
  logic iBusy;
  int iStart;
  logic [memAddrBits-1:0] iWord;
  logic iHit;
  // load or store in flight
  logic dBusy;
  int dStart;
  logic [memAddrBits-1:0] dWord;
  logic dHit;
  logic dStore;

  initial
  begin
    for (int i = 0; i < 2 ** memAddrBits; i++)
    begin
      model[i] = '0;
    end
  end

  function automatic int blockOf(logic [memAddrBits-1:0] word);
    return int'(word / memBusPkg::blockWords);
  endfunction

  function automatic logic [indexBits-1:0] indexOf(logic [memAddrBits-1:0] word);
    return indexBits'(blockOf(word) % lines);
  endfunction

  // a hit answers in one cycle, anything else costs at least one memory turn
  task automatic gradeLatency(input string port, input int latency, input logic hit);
    if (hit && latency != 1)
    begin
      latencyErrors++;
      $display("[ERROR] %0t: %s hit took %0d cycles, expected 1", $time, port, latency);
    end
    else if (!hit && (latency < missMin || latency > missMax))
    begin
      latencyErrors++;
      $display("[ERROR] %0t: %s miss took %0d cycles, expected %0d to %0d",
               $time, port, latency, missMin, missMax);
    end
  endtask

  task automatic fetchMonitor();
    if (iBusy && iValid)
    begin
      iBusy = 1'b0;
      completions++;
      gradeLatency("fetch", cycle - iStart, iHit);
      if (iRd !== model[iWord])
      begin
        valueErrors++;
        $display("[ERROR] %0t: fetch of word %0d returned %h, expected %h",
                 $time, iWord, iRd, model[iWord]);
      end
      // line now holds this block
      iLine[indexOf(iWord)] = blockOf(iWord);
    end
    else if (iBusy && (!iRe || iAddr[memAddrBits+1:2] != iWord))
    begin
      protocolErrors++;
      $display("fetch request dropped or changed before iValid at time %0t", $time);
    end
    else if (!iBusy && iValid)
    begin
      protocolErrors++;
      $display("iValid pulsed with no fetch outstanding at time %0t", $time);
    end
    else if (!iBusy && iRe)
    begin
      iBusy = 1'b1;
      iStart = cycle;
      iWord = iAddr[memAddrBits+1:2];
      iHit = (iLine[indexOf(iWord)] == blockOf(iWord));
    end
  endtask

  task automatic dataMonitor();
    if (dBusy && dValid)
    begin
      dBusy = 1'b0;
      completions++;
      gradeLatency(dStore ? "store" : "load", cycle - dStart, dHit);
      if (!dStore && dRd !== model[dWord])
      begin
        valueErrors++;
        $display("[ERROR] %0t: load of word %0d returned %h, expected %h",
                 $time, dWord, dRd, model[dWord]);
      end
      // loads allocate, stores never do
      if (!dStore)
        dLine[indexOf(dWord)] = blockOf(dWord);
    end
    else if (dBusy && (!(dRe || dWe) || dWe != dStore || dAddr[memAddrBits+1:2] != dWord))
    begin
      protocolErrors++;
      $display("data request dropped or changed before dValid at time %0t", $time);
    end
    else if (!dBusy && dValid)
    begin
      protocolErrors++;
      $display("dValid pulsed with no data access outstanding at time %0t", $time);
    end
    else if (!dBusy && (dRe || dWe))
    begin
      dBusy = 1'b1;
      dStart = cycle;
      dStore = dWe;
      dWord = dAddr[memAddrBits+1:2];
      // stores always go through to memory
      dHit = !dWe && (dLine[indexOf(dWord)] == blockOf(dWord));
      if (dWe)
        model[dWord] = dWd;
    end
  endtask

  // inputs seen as they were just before the edge
  always @(posedge clk)
  begin
    if (!rstN)
    begin
      cycle = 0;
      iBusy = 1'b0;
      dBusy = 1'b0;
      valueErrors = 0;
      latencyErrors = 0;
      protocolErrors = 0;
      completions = 0;
      for (int k = 0; k < lines; k++)
      begin
        iLine[k] = -1;
        dLine[k] = -1;
      end
    end
    else
    begin
      cycle++;
      fetchMonitor();
      dataMonitor();
    end
  end

endmodule

/* tb/memSubsystemTb.sv */
`timescale 1ns/10ps

module memSubsystemTb;

  localparam int waitCycles = 3;
  localparam int memAddrBits = 12;
  localparam int indexBits = 3;
  localparam int codeWrites = 64;
  localparam int phaseTwoOps = 200;
  // every access at most two memory turns, plus slack for reset
  localparam int timeoutCycles = (codeWrites + 2 * phaseTwoOps) * (2 * waitCycles + 8) + 100;

  logic clk;
  logic rstN;
  logic iRe;
  logic [memAddrBits+1:0] iAddr;
  logic [memBusPkg::wordBits-1:0] iRd;
  logic iValid;
  logic dRe;
  logic dWe;
  logic [memAddrBits+1:0] dAddr;
  logic [memBusPkg::wordBits-1:0] dWd;
  logic [memBusPkg::wordBits-1:0] dRd;
  logic dValid;

  int valueErrors;
  int latencyErrors;
  int protocolErrors;
  int completions;
  int otherErrors;
  int cycles = 0;
  logic [31:0] seed = 32'h57ca_7fd8;

  // phase two stimulus, drawn before the ports run side by side
  int fetchWord [phaseTwoOps];
  int dataWord [phaseTwoOps];
  logic dataStore [phaseTwoOps];
  logic [31:0] dataVal [phaseTwoOps];

  memSubsystem #(
    .waitCycles(waitCycles),
    .memAddrBits(memAddrBits),
    .indexBits(indexBits)
  ) dut (
    .clk(clk), .rstN(rstN),
    .iRe(iRe), .iAddr(iAddr), .iRd(iRd), .iValid(iValid),
    .dRe(dRe), .dWe(dWe), .dAddr(dAddr), .dWd(dWd), .dRd(dRd), .dValid(dValid)
  );

  memChecker #(
    .waitCycles(waitCycles),
    .memAddrBits(memAddrBits),
    .indexBits(indexBits)
  ) scoreboard (
    .clk(clk), .rstN(rstN),
    .iRe(iRe), .iAddr(iAddr), .iRd(iRd), .iValid(iValid),
    .dRe(dRe), .dWe(dWe), .dAddr(dAddr), .dWd(dWd), .dRd(dRd), .dValid(dValid),
    .valueErrors(valueErrors), .latencyErrors(latencyErrors),
    .protocolErrors(protocolErrors), .completions(completions)
  );

  always #50 clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles)
    begin
      $display("timeout: test did not finish within %0d cycles", timeoutCycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // upper bits, the low ones of an LCG repeat quickly
  function automatic int randBelow(int n);
    return int'((nextRand() >> 8) % n);
  endfunction

  function automatic logic [memAddrBits+1:0] byteAddr(int word);
    return {word[memAddrBits-1:0], 2'b00};
  endfunction

  // hold the fetch until iValid, return on the edge that saw it
  task automatic fetch(int word);
    iRe <= 1'b1;
    iAddr <= byteAddr(word);
    @(posedge clk);
    while (!iValid)
      @(posedge clk);
  endtask

  task automatic dataAccess(logic store, int word, logic [31:0] value);
    dRe <= !store;
    dWe <= store;
    dAddr <= byteAddr(word);
    dWd <= value;
    @(posedge clk);
    while (!dValid)
      @(posedge clk);
  endtask

  initial
  begin
    clk = 1'b0;
    rstN = 1'b0;
    iRe = 1'b0;
    iAddr = '0;
    dRe = 1'b0;
    dWe = 1'b0;
    dAddr = '0;
    dWd = '0;
    otherErrors = 0;
    // code fetches over 16 blocks, data over 12, so lines get reused
    for (int i = 0; i < phaseTwoOps; i++)
    begin
      fetchWord[i] = randBelow(64);
      dataWord[i] = 256 + randBelow(48);
      dataStore[i] = (randBelow(3) == 0);
      dataVal[i] = nextRand();
    end
    // first data access a load, both ports miss on the same cycle
    dataStore[0] = 1'b0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    // phase one, code region written through the data port
    for (int i = 0; i < codeWrites; i++)
    begin
      dataAccess(1'b1, i, nextRand());
    end
    // phase two, both ports busy at once
    fork
      begin
        for (int i = 0; i < phaseTwoOps; i++)
          fetch(fetchWord[i]);
        iRe <= 1'b0;
      end
      begin
        for (int i = 0; i < phaseTwoOps; i++)
          dataAccess(dataStore[i], dataWord[i], dataVal[i]);
        dRe <= 1'b0;
        dWe <= 1'b0;
      end
    join
    repeat (5) @(posedge clk);
    if (completions != codeWrites + 2 * phaseTwoOps)
    begin
      otherErrors++;
      $display("checker counted %0d completions instead of %0d",
               completions, codeWrites + 2 * phaseTwoOps);
    end
    $display("errors: value %0d, latency %0d, protocol %0d, other %0d",
             valueErrors, latencyErrors, protocolErrors, otherErrors);
    if (valueErrors + latencyErrors + protocolErrors + otherErrors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* verilog.f */
hdl/memBusPkg.sv
hdl/cacheTypesPkg.sv
hdl/blockMemory.sv
hdl/instrCache.sv
hdl/dataCache.sv
hdl/memArbiter.sv
hdl/memSubsystem.sv
tb/memChecker.sv
tb/memSubsystemTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= memSubsystemTb
FLAGS ?= --binary --timing
OBJDIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f verilog.f

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)
